//--- common/crt_pkg.sv
package crt_pkg;

   // character cell geometry
   localparam int CHAR_W    = 6;   // pixels per glyph row
   localparam int CHAR_H    = 12;  // scanlines per glyph
   localparam int ROW_REP   = 3;   // each scanline drawn three times
   localparam int FETCH_LAT = 4;   // beam position to pixel bit, both planes

   // counter widths derived from the cell geometry
   localparam int PX_W   = $clog2(CHAR_W);
   localparam int LINE_W = $clog2(CHAR_H);
   localparam int REP_W  = $clog2(ROW_REP);

   typedef logic [7:0]        code_t;   // bit 7 set selects 2x3 block graphics
   typedef logic [CHAR_W-1:0] glyph_t;  // msb is the leftmost pixel
   typedef logic [CHAR_W-1:0] gfx_t;    // bit 0 is the leftmost pixel

   // which RAM the external write port hits
   typedef enum logic [1:0]
   {
      WR_TEXT,
      WR_GLYPH,
      WR_GFX
   } wr_target_t;

endpackage

//--- hdl/video_ram.sv
`timescale 1ns/100ps

module video_ram import crt_pkg::*;
#(
   parameter int  DEPTH  = 1024,
   parameter type word_t = code_t,
   localparam int AW = $clog2(DEPTH)
)
(
   input  logic          vga_clk,
   input  logic          we,
   input  logic [AW-1:0] waddr,
   input  word_t         wdata,
   input  logic          re,
   input  logic [AW-1:0] raddr,
   output word_t         rdata
);

   word_t mem [DEPTH];

   // write port
   always_ff @(posedge vga_clk)
   begin
      if (we)
         mem[waddr] <= wdata;
   end

   // registered read, holds between strobes
   // same-cycle read of a written word sees the old value
   always_ff @(posedge vga_clk)
   begin
      if (re)
         rdata <= mem[raddr];
   end

endmodule

//--- hdl/beam_counter.sv
`timescale 1ns/100ps

module beam_counter import crt_pkg::*;
#(
   parameter int COLS          = 64,
   parameter int ROWS          = 16,
   parameter int H_BLANK_CELLS = 24,
   parameter int V_BLANK_LINES = 24,
   parameter int H_SYNC_CELL   = 5,
   parameter int V_SYNC_LINE   = 2,
   localparam int CW = $clog2(COLS + H_BLANK_CELLS),
   localparam int RW = $clog2(ROWS + 1)
)
(
   input  logic              vga_clk,
   input  logic              rst_n,
   output logic [CW-1:0]     col,      // character column, blank cells past COLS
   output logic [PX_W-1:0]   cell_px,  // pixel within the cell
   output logic [LINE_W-1:0] line,     // glyph scanline
   output logic [REP_W-1:0]  rep,      // repeat of the scanline
   output logic [RW-1:0]     row,      // text row, ROWS during vertical blank
   output logic              beam_act,
   output logic              beam_hs,
   output logic              beam_vs
);

   int  blank_idx;  // line number within the vertical blank
   logic frame_end;

   // in the blank row line and rep just count blank lines
   assign blank_idx = int'(line) * ROW_REP + int'(rep);
   assign frame_end = (int'(row) == ROWS) && (blank_idx == V_BLANK_LINES - 1);

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         cell_px <= '0;
         col     <= '0;
         rep     <= '0;
         line    <= '0;
         row     <= '0;
      end
      else if (int'(cell_px) == CHAR_W - 1)
      begin
         cell_px <= '0;
         if (int'(col) == COLS + H_BLANK_CELLS - 1)
         begin
            col <= '0;  // end of line
            if (frame_end)
            begin
               rep  <= '0;
               line <= '0;
               row  <= '0;
            end
            else if (int'(rep) == ROW_REP - 1)
            begin
               rep <= '0;
               if (int'(line) == CHAR_H - 1)
               begin
                  line <= '0;
                  row  <= row + 1'b1;
               end
               else
                  line <= line + 1'b1;
            end
            else
               rep <= rep + 1'b1;
         end
         else
            col <= col + 1'b1;
      end
      else
         cell_px <= cell_px + 1'b1;
   end

   // active area is exactly the text area
   assign beam_act = (int'(col) < COLS) && (int'(row) < ROWS);
   assign beam_hs  = (int'(col) == COLS + H_SYNC_CELL);  // one cell wide
   assign beam_vs  = (int'(row) == ROWS) && (blank_idx == V_SYNC_LINE);  // one line

endmodule

//--- text/text_plane.sv
`timescale 1ns/100ps

module text_plane import crt_pkg::*;
#(
   parameter int COLS          = 64,
   parameter int ROWS          = 16,
   parameter int H_BLANK_CELLS = 24,
   localparam int CW = $clog2(COLS + H_BLANK_CELLS),
   localparam int RW = $clog2(ROWS + 1)
)
(
   input  logic              vga_clk,
   input  logic              rst_n,
   input  logic [CW-1:0]     col,
   input  logic [PX_W-1:0]   cell_px,
   input  logic [LINE_W-1:0] line,
   input  logic [RW-1:0]     row,
   input  logic              beam_act,
   input  logic              wide,      // 32 column mode
   input  logic              txt_we,
   input  logic              glyph_we,
   input  logic [13:0]       wr_addr,
   input  logic [7:0]        wr_data,
   output logic              txt_pix
);

   localparam int TA_W = $clog2(COLS * ROWS);
   localparam int GDEPTH = 256 * CHAR_H;  // every code has a glyph slot
   localparam int GA_W = $clog2(GDEPTH);

   logic                 cell_start;
   logic                 skip_cell;
   logic [FETCH_LAT-2:0] ld_pipe;   // cell load strobe in flight
   logic [FETCH_LAT-2:0] act_pipe;  // active flag riding along
   logic [CW-1:0]        col_rd;
   logic [TA_W-1:0]      txt_raddr;
   logic [GA_W-1:0]      glyph_raddr;
   code_t                txt_code;
   code_t                code_q;
   logic [LINE_W-1:0]    line_q;
   logic [LINE_W-3:0]    blk_grp;
   glyph_t               glyph_row;
   glyph_t               blk_pat;
   glyph_t               shift_q;
   logic                 shift_en;

   assign cell_start = (cell_px == '0);
   assign skip_cell  = wide & col[0];  // odd cells keep the even cell's pixels
   assign col_rd     = wide ? {col[CW-1:1], 1'b0} : col;
   assign txt_raddr  = TA_W'(int'(row) * COLS + int'(col_rd));

   video_ram #(.DEPTH(COLS * ROWS), .word_t(code_t)) i_text_ram
   (
      .vga_clk (vga_clk),
      .we      (txt_we),
      .waddr   (wr_addr[TA_W-1:0]),
      .wdata   (wr_data),
      .re      (cell_start & beam_act),
      .raddr   (txt_raddr),
      .rdata   (txt_code)
   );

   // glyph row address straight off the text RAM output
   assign glyph_raddr = GA_W'(int'(txt_code) * CHAR_H + int'(line_q));

   video_ram #(.DEPTH(GDEPTH), .word_t(glyph_t)) i_glyph_ram
   (
      .vga_clk (vga_clk),
      .we      (glyph_we),
      .waddr   (wr_addr[GA_W-1:0]),
      .wdata   (wr_data[CHAR_W-1:0]),  // only the low 6 bits are glyph
      .re      (ld_pipe[0] & act_pipe[0]),
      .raddr   (glyph_raddr),
      .rdata   (glyph_row)
   );

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         ld_pipe  <= '0;
         act_pipe <= '0;
      end
      else
      begin
         ld_pipe  <= {ld_pipe[FETCH_LAT-3:0], cell_start & ~skip_cell};
         act_pipe <= {act_pipe[FETCH_LAT-3:0], beam_act};
      end
   end

   // code and line follow the fetch, held until the next cell
   always_ff @(posedge vga_clk)
   begin
      if (cell_start)
         line_q <= line;
      if (ld_pipe[0])
         code_q <= txt_code;
   end

   // 2x3 blocks, one bit pair per third of the cell height
   assign blk_grp = line_q[LINE_W-1:2];
   assign blk_pat = {{3{code_q[{blk_grp, 1'b0}]}}, {3{code_q[{blk_grp, 1'b1}]}}};

   assign shift_en = ~wide | cell_px[0];  // wide mode doubles every pixel

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
         shift_q <= '0;
      else if (ld_pipe[FETCH_LAT-2])
         shift_q <= act_pipe[FETCH_LAT-2] ? (code_q[7] ? blk_pat : glyph_row) : '0;
      else if (shift_en)
         shift_q <= {shift_q[CHAR_W-2:0], 1'b0};  // msb goes out first
   end

   assign txt_pix = shift_q[CHAR_W-1];

endmodule

//--- graphics/graphics_plane.sv
`timescale 1ns/100ps

module graphics_plane import crt_pkg::*;
#(
   parameter int COLS          = 64,
   parameter int ROWS          = 16,
   parameter int H_BLANK_CELLS = 24,
   localparam int CW = $clog2(COLS + H_BLANK_CELLS),
   localparam int RW = $clog2(ROWS + 1)
)
(
   input  logic              vga_clk,
   input  logic              rst_n,
   input  logic [CW-1:0]     col,
   input  logic [PX_W-1:0]   cell_px,
   input  logic [LINE_W-1:0] line,
   input  logic [RW-1:0]     row,
   input  logic              beam_act,
   input  logic              gfx_we,
   input  logic [13:0]       wr_addr,
   input  logic [7:0]        wr_data,
   output logic              gfx_pix
);

   localparam int GFX_DEPTH = ROWS * CHAR_H * COLS;  // one word per scanline cell
   localparam int GFA_W = $clog2(GFX_DEPTH);

   logic                 cell_start;
   logic [FETCH_LAT-2:0] ld_pipe;
   logic [FETCH_LAT-2:0] act_pipe;
   logic [GFA_W-1:0]     gfx_raddr;
   gfx_t                 gfx_word;
   gfx_t                 word_q;
   gfx_t                 word_rev;
   gfx_t                 shift_q;

   assign cell_start = (cell_px == '0);
   // scanline index row*CHAR_H+line, then column
   assign gfx_raddr = GFA_W'((int'(row) * CHAR_H + int'(line)) * COLS + int'(col));

   video_ram #(.DEPTH(GFX_DEPTH), .word_t(gfx_t)) i_gfx_ram
   (
      .vga_clk (vga_clk),
      .we      (gfx_we),
      .waddr   (wr_addr[GFA_W-1:0]),
      .wdata   (wr_data[CHAR_W-1:0]),
      .re      (cell_start & beam_act),
      .raddr   (gfx_raddr),
      .rdata   (gfx_word)
   );

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         ld_pipe  <= '0;
         act_pipe <= '0;
      end
      else
      begin
         ld_pipe  <= {ld_pipe[FETCH_LAT-3:0], cell_start};
         act_pipe <= {act_pipe[FETCH_LAT-3:0], beam_act};
      end
   end

   // pad stage, keeps the load in step with the text plane
   always_ff @(posedge vga_clk)
   begin
      if (ld_pipe[0])
         word_q <= gfx_word;
   end

   // bit 0 is leftmost here, so flip before shifting msb first
   always_comb
   begin
      for (int i = 0; i < CHAR_W; i++)
         word_rev[i] = word_q[CHAR_W-1-i];
   end

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
         shift_q <= '0;
      else if (ld_pipe[FETCH_LAT-2])
         shift_q <= act_pipe[FETCH_LAT-2] ? word_rev : '0;  // blank outside active
      else
         shift_q <= {shift_q[CHAR_W-2:0], 1'b0};
   end

   assign gfx_pix = shift_q[CHAR_W-1];

endmodule

//--- hdl/pixel_mixer.sv
`timescale 1ns/100ps

module pixel_mixer import crt_pkg::*;
(
   input  logic vga_clk,
   input  logic rst_n,
   input  logic txt_pix,
   input  logic gfx_pix,
   input  logic graph_en,   // overlay enable
   input  logic beam_act,
   input  logic beam_hs,
   input  logic beam_vs,
   output logic pixel_data,
   output logic video_act,
   output logic h_sync,
   output logic v_sync
);

   // beam flags wait for the plane fetch
   logic [FETCH_LAT-1:0] act_dly;
   logic [FETCH_LAT-1:0] hs_dly;
   logic [FETCH_LAT-1:0] vs_dly;
   logic                 mix_pix;

   assign mix_pix = (graph_en & gfx_pix) ^ txt_pix;  // graphics xor text

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         act_dly    <= '0;
         hs_dly     <= '0;
         vs_dly     <= '0;
         pixel_data <= 1'b0;
         video_act  <= 1'b0;
         h_sync     <= 1'b0;
         v_sync     <= 1'b0;
      end
      else
      begin
         act_dly    <= {act_dly[FETCH_LAT-2:0], beam_act};
         hs_dly     <= {hs_dly[FETCH_LAT-2:0], beam_hs};
         vs_dly     <= {vs_dly[FETCH_LAT-2:0], beam_vs};
         pixel_data <= mix_pix;  // lines up with the oldest flag stage
         video_act  <= act_dly[FETCH_LAT-1];
         h_sync     <= hs_dly[FETCH_LAT-1];
         v_sync     <= vs_dly[FETCH_LAT-1];
      end
   end

endmodule

//--- hdl/crt_video.sv
`timescale 1ns/100ps

module crt_video import crt_pkg::*;
#(
   parameter int COLS          = 64,
   parameter int ROWS          = 16,
   parameter int H_BLANK_CELLS = 24,
   parameter int V_BLANK_LINES = 24,
   parameter int H_SYNC_CELL   = 5,
   parameter int V_SYNC_LINE   = 2
)
(
   input  logic        vga_clk,
   input  logic        rst_n,
   input  logic        wr_en,      // single cycle strobe
   input  wr_target_t  wr_target,
   input  logic [13:0] wr_addr,
   input  logic [7:0]  wr_data,
   input  logic        wide,
   input  logic        graph_en,
   output logic        pixel_data,
   output logic        video_act,
   output logic        h_sync,
   output logic        v_sync
);

   localparam int CW = $clog2(COLS + H_BLANK_CELLS);
   localparam int RW = $clog2(ROWS + 1);

   logic [CW-1:0]     col;
   logic [PX_W-1:0]   cell_px;
   logic [LINE_W-1:0] line;
   logic [RW-1:0]     row;
   logic              beam_act;
   logic              beam_hs;
   logic              beam_vs;
   logic              txt_we;
   logic              glyph_we;
   logic              gfx_we;
   logic              txt_pix;
   logic              gfx_pix;

   // one enable per RAM, address and data shared
   assign txt_we   = wr_en && (wr_target == WR_TEXT);
   assign glyph_we = wr_en && (wr_target == WR_GLYPH);
   assign gfx_we   = wr_en && (wr_target == WR_GFX);

   beam_counter #(
      .COLS          (COLS),
      .ROWS          (ROWS),
      .H_BLANK_CELLS (H_BLANK_CELLS),
      .V_BLANK_LINES (V_BLANK_LINES),
      .H_SYNC_CELL   (H_SYNC_CELL),
      .V_SYNC_LINE   (V_SYNC_LINE)
   ) i_beam (
      .vga_clk  (vga_clk),
      .rst_n    (rst_n),
      .col      (col),
      .cell_px  (cell_px),
      .line     (line),
      .rep      (),          // scanline repeat only matters inside the counter
      .row      (row),
      .beam_act (beam_act),
      .beam_hs  (beam_hs),
      .beam_vs  (beam_vs)
   );

   text_plane #(.COLS(COLS), .ROWS(ROWS), .H_BLANK_CELLS(H_BLANK_CELLS)) i_text
   (
      .vga_clk  (vga_clk),
      .rst_n    (rst_n),
      .col      (col),
      .cell_px  (cell_px),
      .line     (line),
      .row      (row),
      .beam_act (beam_act),
      .wide     (wide),
      .txt_we   (txt_we),
      .glyph_we (glyph_we),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .txt_pix  (txt_pix)
   );

   graphics_plane #(.COLS(COLS), .ROWS(ROWS), .H_BLANK_CELLS(H_BLANK_CELLS)) i_gfx
   (
      .vga_clk  (vga_clk),
      .rst_n    (rst_n),
      .col      (col),
      .cell_px  (cell_px),
      .line     (line),
      .row      (row),
      .beam_act (beam_act),
      .gfx_we   (gfx_we),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .gfx_pix  (gfx_pix)
   );

   // final register stage, all four outputs together
   pixel_mixer i_mixer
   (
      .vga_clk    (vga_clk),
      .rst_n      (rst_n),
      .txt_pix    (txt_pix),
      .gfx_pix    (gfx_pix),
      .graph_en   (graph_en),
      .beam_act   (beam_act),
      .beam_hs    (beam_hs),
      .beam_vs    (beam_vs),
      .pixel_data (pixel_data),
      .video_act  (video_act),
      .h_sync     (h_sync),
      .v_sync     (v_sync)
   );

endmodule

//--- bench/tb_crt_video.sv
`timescale 1ns/100ps

module tb_crt_video import crt_pkg::*;
();

   // small screen of about 5.6k cycles per frame
   localparam int COLS        = 8;
   localparam int ROWS        = 2;
   localparam int H_BLANK     = 4;
   localparam int V_BLANK     = 6;
   localparam int LINE_CYC    = (COLS + H_BLANK) * CHAR_W;
   localparam int ACT_LINES   = ROWS * CHAR_H * ROW_REP;
   localparam int FRAME_CYC   = (ACT_LINES + V_BLANK) * LINE_CYC;
   localparam int ACT_W       = COLS * CHAR_W;
   localparam int SLACK       = 12;  // cycles left before the next v_sync for writes
   localparam int TXT_DEPTH   = COLS * ROWS;
   localparam int GLYPH_DEPTH = 256 * CHAR_H;
   localparam int GFX_DEPTH   = ROWS * CHAR_H * COLS;

   logic        vga_clk;
   logic        rst_n;
   logic        wr_en;
   wr_target_t  wr_target;
   logic [13:0] wr_addr;
   logic [7:0]  wr_data;
   logic        wide;
   logic        graph_en;
   logic        pixel_data;
   logic        video_act;
   logic        h_sync;
   logic        v_sync;

   // reference copies of the three RAMs
   logic [7:0]        text_mem  [TXT_DEPTH];
   logic [CHAR_W-1:0] glyph_mem [GLYPH_DEPTH];
   logic [CHAR_W-1:0] gfx_mem   [GFX_DEPTH];

   byte cmd_q [$];   // command letters from the case file
   int  arg_a [$];
   int  arg_b [$];
   int  arg_c [$];
   int  num_frames;
   int  cycle_cnt;
   int  cycle_limit;
   int  seed_dummy;

   crt_video #(
      .COLS          (COLS),
      .ROWS          (ROWS),
      .H_BLANK_CELLS (H_BLANK),
      .V_BLANK_LINES (V_BLANK),
      .H_SYNC_CELL   (1),   // must sit inside the 4 blank cells
      .V_SYNC_LINE   (2)
   ) i_dut (
      .vga_clk    (vga_clk),
      .rst_n      (rst_n),
      .wr_en      (wr_en),
      .wr_target  (wr_target),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wide       (wide),
      .graph_en   (graph_en),
      .pixel_data (pixel_data),
      .video_act  (video_act),
      .h_sync     (h_sync),
      .v_sync     (v_sync)
   );

   always #20 vga_clk = ~vga_clk;  // 40 ns period

   // run limit is set once the case file is counted
   always @(posedge vga_clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $fatal(1, "timeout");
      end
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1, "stopped at first error");
      end
   endtask

   // pixel from the display rules where line_idx counts active lines
   function automatic logic expected_pixel(input int line_idx, input int x);
      int          row;
      int          line;
      int          col;
      int          px;
      int          grp;
      logic [7:0]  code;
      logic [CHAR_W-1:0] gword;
      logic        txt;
      row  = line_idx / (CHAR_H * ROW_REP);
      line = (line_idx / ROW_REP) % CHAR_H;
      col  = wide ? 2 * (x / (2 * CHAR_W)) : x / CHAR_W;     // even cells only in wide
      px   = wide ? (x % (2 * CHAR_W)) / 2 : x % CHAR_W;     // doubled pixels
      code = text_mem[row * COLS + col];
      grp  = line / 4;                                        // block third of the cell
      if (code[7])
         txt = (px < 3) ? code[2 * grp] : code[2 * grp + 1];  // even bit on the left
      else
         txt = glyph_mem[int'(code) * CHAR_H + line][CHAR_W - 1 - px];  // msb leftmost
      gword = gfx_mem[(row * CHAR_H + line) * COLS + x / CHAR_W];
      return txt ^ (graph_en & gword[x % CHAR_W]);          // bit 0 leftmost
   endfunction

   task automatic release_bus;
      if (wr_en)
      begin
         @(negedge vga_clk);
         wr_en = 1'b0;
      end
   endtask

   // one write per cycle with the strobe held across a burst
   task automatic write_word(input int target, input int addr, input int data);
      @(negedge vga_clk);
      wr_en     = 1'b1;
      wr_target = wr_target_t'(target);
      wr_addr   = 14'(addr);
      wr_data   = 8'(data);
      case (wr_target_t'(target))
         WR_TEXT:  text_mem[addr]  = 8'(data);
         WR_GLYPH: glyph_mem[addr] = CHAR_W'(data);  // low bits only
         default:  gfx_mem[addr]   = CHAR_W'(data);
      endcase
   endtask

   task automatic fill_random(input int target);
      int depth;
      depth = (target == 0) ? TXT_DEPTH : (target == 1) ? GLYPH_DEPTH : GFX_DEPTH;
      for (int i = 0; i < depth; i++)
         write_word(target, i, $urandom & 8'hff);
      release_bus();
   endtask

   task automatic read_cases;
      int    fd;
      int    n;
      int    a;
      int    b;
      int    c;
      byte   cmd;
      string line_s;
      fd = $fopen("bench/video_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open bench/video_cases.txt");
         $display("Done: errors found");
         $fatal(1, "no case file");
      end
      while (!$feof(fd))
      begin
         line_s = "";
         n = $fgets(line_s, fd);
         if (n > 0)
         begin
            cmd = line_s.getc(0);
            if (cmd == "W" || cmd == "R" || cmd == "M" || cmd == "F")  // rest is comment
            begin
               a = 0;
               b = 0;
               c = 0;
               n = $sscanf(line_s.substr(1, line_s.len() - 1), "%h %h %h", a, b, c);
               cmd_q.push_back(cmd);
               arg_a.push_back(a);
               arg_b.push_back(b);
               arg_c.push_back(c);
               if (cmd == "F")
                  num_frames++;
            end
         end
      end
      $fclose(fd);
   endtask

   // timing and every pixel of the frame after one v_sync rise
   task automatic check_frame;
      int   x;
      int   act_lines;
      int   hs_rises;
      int   vs_rises;
      logic prev_act;
      logic prev_hs;
      logic prev_vs;
      release_bus();
      prev_vs = v_sync;
      @(negedge vga_clk);
      while (!v_sync || prev_vs)
      begin
         prev_vs = v_sync;
         @(negedge vga_clk);
      end
      x         = 0;
      act_lines = 0;
      hs_rises  = 0;
      vs_rises  = 1;   // the rise just seen
      prev_act  = video_act;
      prev_hs   = h_sync;
      prev_vs   = v_sync;
      repeat (FRAME_CYC - SLACK - 1)
      begin
         @(negedge vga_clk);
         if (video_act)
         begin
            if (x < ACT_W && act_lines < ACT_LINES)
               check_val("pixel_data", pixel_data, expected_pixel(act_lines, x));
            x++;
         end
         else
         begin
            check_val("pixel_data", pixel_data, 0);  // dark outside the text area
            if (prev_act)
            begin
               check_val("active_width", x, ACT_W);
               act_lines++;
               x = 0;
            end
         end
         if (h_sync && !prev_hs)
            hs_rises++;
         if (v_sync && !prev_vs)
            vs_rises++;
         prev_act = video_act;
         prev_hs  = h_sync;
         prev_vs  = v_sync;
      end
      check_val("active_lines", act_lines, ACT_LINES);
      check_val("h_sync_pulses", hs_rises, ACT_LINES + V_BLANK);
      check_val("v_sync_pulses", vs_rises, 1);
   endtask

   initial
   begin
      vga_clk     = 1'b0;
      rst_n       = 1'b0;
      wr_en       = 1'b0;
      wr_target   = WR_TEXT;
      wr_addr     = '0;
      wr_data     = '0;
      wide        = 1'b0;
      graph_en    = 1'b0;
      cycle_cnt   = 0;
      cycle_limit = 0;
      num_frames  = 0;
      seed_dummy  = $urandom(32'h3ab2);
      read_cases();
      cycle_limit = (num_frames + 2) * FRAME_CYC + 1000;
      repeat (16)
      begin
         @(negedge vga_clk);
         check_val("pixel_data", pixel_data, 0);  // all outputs held low
         check_val("video_act", video_act, 0);
         check_val("h_sync", h_sync, 0);
         check_val("v_sync", v_sync, 0);
      end
      rst_n = 1'b1;
      for (int i = 0; i < cmd_q.size(); i++)
      begin
         case (cmd_q[i])
            "W": write_word(arg_a[i], arg_b[i], arg_c[i]);
            "R": fill_random(arg_a[i]);
            "M":
            begin
               release_bus();
               wide     = (arg_a[i] != 0);  // applied on the current falling edge
               graph_en = (arg_b[i] != 0);
            end
            default: check_frame();
         endcase
      end
      release_bus();
      $display("Done: no errors");
      $finish;
   end

endmodule

//--- bench/video_cases.txt
# W target addr data | R target | M wide graph_en | F check one frame (hex fields)
# targets 0 text, 1 glyph, 2 graphics
R 1
R 0
R 2
M 0 0
F
M 0 1
F
M 1 1
F
M 1 0
F
W 1 30C 2D   glyph 0x41 line 0
W 1 30D 12   glyph 0x41 line 1
W 0 3 41     row 0 col 3 glyph code
W 0 9 A5     row 1 col 1 block code
W 2 5 3F     scanline 0 col 5
W 2 60 15    scanline 12 col 0
M 0 1
F

//--- sim.f
common/crt_pkg.sv
hdl/video_ram.sv
hdl/beam_counter.sv
text/text_plane.sv
graphics/graphics_plane.sv
hdl/pixel_mixer.sv
hdl/crt_video.sv
bench/tb_crt_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build tb_crt_video with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_crt_video -f sim.f \
   -o tb_crt_video > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_crt_video > sim.log 2>&1
cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
